// ==== src.f ====
logic/rv_pkg.sv
logic/fetch_unit.sv
logic/reg_file.sv
logic/decode_stage.sv
logic/alu.sv
logic/execute_stage.sv
logic/retire_stages.sv
logic/rv_core.sv
test/tb_clock.sv
test/tb_rv_core.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - logic/rv_pkg.sv
  - logic/fetch_unit.sv
  - logic/reg_file.sv
  - logic/decode_stage.sv
  - logic/alu.sv
  - logic/execute_stage.sv
  - logic/retire_stages.sv
  - logic/rv_core.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/tb_rv_core.sv

// ==== test/tb_rv_core.sv ====
module tb_rv_core import rv_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int imem_words = 1024;
  localparam int max_steps  = 4000;
  localparam logic [xlen-1:0] nop_word   = {20'b0, 5'd0, opc_reg_imm};
  localparam logic [xlen-1:0] ecall_word = {25'b0, opc_environ};

  logic                 clk;
  logic                 rst = 1'b1;
  logic [xlen-1:0]      pc_to_imem;
  logic [xlen-1:0]      insn_from_imem;
  logic                 halt;
  logic [xlen-1:0]      trace_writeback_pc;
  logic [xlen-1:0]      trace_writeback_insn;
  logic [status_w-1:0]  trace_writeback_cycle_status;
  logic                 trace_writeback_we;
  logic [reg_idx_w-1:0] trace_writeback_rd;
  logic [xlen-1:0]      trace_writeback_rd_data;

  logic [xlen-1:0] imem [imem_words];
  int              prog_len = 0;
  int              seed = 25;
  int              cycle_count = 0;
  int              cycle_limit = 40;

  // expected writeback trace, one entry per slot after the reset slots
  logic [status_w-1:0]  exp_status [$];
  logic [xlen-1:0]      exp_pc [$];
  logic [xlen-1:0]      exp_insn [$];
  logic                 exp_we [$];
  logic [reg_idx_w-1:0] exp_rd [$];
  logic [xlen-1:0]      exp_data [$];

  tb_clock #(.period_ns(8.0)) u_clock (.clk(clk));

  rv_core #(.reset_pc('0)) uut (
    .clk(clk), .rst(rst), .pc_to_imem(pc_to_imem), .insn_from_imem(insn_from_imem),
    .halt(halt), .trace_writeback_pc(trace_writeback_pc),
    .trace_writeback_insn(trace_writeback_insn),
    .trace_writeback_cycle_status(trace_writeback_cycle_status),
    .trace_writeback_we(trace_writeback_we), .trace_writeback_rd(trace_writeback_rd),
    .trace_writeback_rd_data(trace_writeback_rd_data)
  );

  // instruction memory answers in the same cycle, nop outside the program
  always_comb begin
    if (pc_to_imem[xlen-1:2] < prog_len) begin
      insn_from_imem = imem[pc_to_imem[11:2]];
    end else begin
      insn_from_imem = nop_word;
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      abort_run($sformatf("timeout after %0d cycles, the core never reached the halt",
                          cycle_limit));
    end
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_word(input string test, input string what,
                            input logic [xlen-1:0] exp, input logic [xlen-1:0] act);
    if (act !== exp) begin
      abort_run($sformatf("CHECK FAILED %s %s expected %h actual %h", test, what, exp, act));
    end
  endtask

  task automatic check_status(input string test, input string what,
                              input logic [status_w-1:0] exp, input logic [status_w-1:0] act);
    if (act !== exp) begin
      abort_run($sformatf("CHECK FAILED %s %s expected %0d actual %0d", test, what, exp, act));
    end
  endtask

  task automatic check_bit(input string test, input string what, input logic exp,
                           input logic act);
    if (act !== exp) begin
      abort_run($sformatf("CHECK FAILED %s %s expected %b actual %b", test, what, exp, act));
    end
  endtask

  // instruction word builders
  function automatic logic [xlen-1:0] r_word(input int f7, input int f3, input int rd,
                                             input int rs1, input int rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opc_reg_reg};
  endfunction

  function automatic logic [xlen-1:0] i_word(input int f3, input int rd, input int rs1,
                                             input int imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc_reg_imm};
  endfunction

  function automatic logic [xlen-1:0] b_word(input int f3, input int rs1, input int rs2,
                                             input int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], opc_branch};
  endfunction

  function automatic logic [xlen-1:0] u_word(input int rd, input int imm);
    return {imm[19:0], rd[4:0], opc_lui};
  endfunction

  task automatic new_program();
    prog_len = 0;
  endtask

  task automatic emit(input logic [xlen-1:0] word);
    imem[prog_len] = word;
    prog_len++;
  endtask

  // rv32i result rules for funct3, alt selects sub and sra
  function automatic logic [xlen-1:0] alu_value(input logic [2:0] f3, input logic alt,
                                                input logic [xlen-1:0] a,
                                                input logic [xlen-1:0] b);
    logic signed [xlen-1:0] sa;
    sa = a;
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return {{(xlen-1){1'b0}}, sa < $signed(b)};
      3'b011:  return {{(xlen-1){1'b0}}, a < b};
      3'b100:  return a ^ b;
      3'b101: begin
        if (alt) begin
          return sa >>> b[4:0];
        end
        return a >> b[4:0];
      end
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_cond(input logic [2:0] f3, input logic [xlen-1:0] a,
                                       input logic [xlen-1:0] b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      3'b111:  return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  task automatic push_slot(input logic [status_w-1:0] status, input logic [xlen-1:0] pc,
                           input logic [xlen-1:0] insn, input logic we,
                           input logic [reg_idx_w-1:0] rd, input logic [xlen-1:0] data);
    exp_status.push_back(status);
    exp_pc.push_back(pc);
    exp_insn.push_back(insn);
    exp_we.push_back(we);
    exp_rd.push_back(rd);
    exp_data.push_back(data);
  endtask

  // steps the loaded program from pc 0 until ecall
  task automatic run_reference();
    logic [xlen-1:0] regs [32];
    logic [xlen-1:0] pc, insn, a, b, res;
    logic [2:0]      f3;
    logic            taken, writes;
    int              steps;
    exp_status.delete();
    exp_pc.delete();
    exp_insn.delete();
    exp_we.delete();
    exp_rd.delete();
    exp_data.delete();
    foreach (regs[r]) begin
      regs[r] = '0;
    end
    pc = '0;
    steps = 0;
    while (steps < max_steps) begin
      insn = (pc[xlen-1:2] < prog_len) ? imem[pc[11:2]] : nop_word;
      f3 = insn[14:12];
      a = regs[insn[19:15]];
      b = regs[insn[24:20]];
      res = '0;
      writes = 1'b0;
      taken = 1'b0;
      case (insn[6:0])
        opc_lui: begin
          res = {insn[31:12], 12'h000};
          writes = 1'b1;
        end
        opc_reg_imm: begin
          res = alu_value(f3, f3 == 3'b101 && insn[30], a, {{20{insn[31]}}, insn[31:20]});
          writes = 1'b1;
        end
        opc_reg_reg: begin
          res = alu_value(f3, insn[30], a, b);
          writes = 1'b1;
        end
        opc_branch: begin
          taken = branch_cond(f3, a, b);
        end
        default: begin
        end
      endcase
      push_slot(cs_no_stall, pc, insn, writes, insn[11:7], res);
      if (insn == ecall_word) begin
        return;
      end
      if (writes && insn[11:7] != 5'd0) begin
        regs[insn[11:7]] = res;
      end
      if (taken) begin
        push_slot(cs_taken_branch, '0, '0, 1'b0, '0, '0);
        push_slot(cs_taken_branch, '0, '0, 1'b0, '0, '0);
        pc = pc + {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
      end else begin
        pc = pc + 32'd4;
      end
      steps++;
    end
    abort_run("reference model ran past its step limit without reaching an ecall");
  endtask

  task automatic check_reset_slot(input string test);
    check_status(test, "reset status", cs_reset, trace_writeback_cycle_status);
    check_bit(test, "reset halt", 1'b0, halt);
    check_bit(test, "reset we", 1'b0, trace_writeback_we);
  endtask

  // rst high for 16 clock periods
  task automatic pulse_reset(input string test);
    @(posedge clk);
    rst <= 1'b1;
    repeat (15) begin
      @(posedge clk);
      @(negedge clk);
      check_reset_slot(test);
    end
    @(posedge clk);
    rst <= 1'b0;
  endtask

  task automatic compare_trace(input string test);
    // first instruction needs four edges to reach writeback
    repeat (4) begin
      @(negedge clk);
      check_reset_slot(test);
    end
    for (int i = 0; i < exp_pc.size(); i++) begin
      @(negedge clk);
      check_status(test, "status", exp_status[i], trace_writeback_cycle_status);
      check_word(test, "pc", exp_pc[i], trace_writeback_pc);
      check_word(test, "insn", exp_insn[i], trace_writeback_insn);
      check_bit(test, "we", exp_we[i], trace_writeback_we);
      check_bit(test, "halt", exp_insn[i] == ecall_word, halt);
      if (exp_we[i]) begin
        check_word(test, "rd", xlen'(exp_rd[i]), xlen'(trace_writeback_rd));
        check_word(test, "rd_data", exp_data[i], trace_writeback_rd_data);
      end
    end
  endtask

  task automatic run_program(input string test);
    run_reference();
    cycle_limit += exp_pc.size() + 40;
    pulse_reset(test);
    compare_trace(test);
  endtask

  task automatic reset_sequence();
    new_program();
    emit(i_word(0, 1, 0, 1));
    emit(i_word(0, 2, 1, 1));
    emit(ecall_word);
    run_program("reset");
  endtask

  task automatic immediate_ops();
    new_program();
    emit(u_word(1, 20'h12345));
    emit(i_word(0, 2, 0, -5));
    emit(i_word(2, 3, 2, -4));
    emit(i_word(3, 4, 2, 3));
    emit(i_word(3, 5, 0, -1));
    emit(i_word(4, 6, 2, 12'h7ff));
    emit(i_word(6, 7, 1, -16));
    emit(i_word(7, 8, 1, 12'h0f0));
    emit(i_word(1, 9, 2, 4));
    emit(i_word(5, 10, 2, 3));
    // srai on a negative and a positive value
    emit(i_word(5, 11, 2, 12'h403));
    emit(i_word(5, 12, 1, 12'h41f));
    emit(i_word(0, 13, 1, -2048));
    emit(u_word(14, 20'hfffff));
    emit(ecall_word);
    run_program("immediate_ops");
  endtask

  task automatic bypass_chains();
    new_program();
    emit(i_word(0, 1, 0, 7));
    emit(i_word(0, 2, 1, 1));
    emit(i_word(0, 3, 0, 100));
    // x2 at distance two, x1 at distance three
    emit(r_word(0, 0, 4, 2, 1));
    emit(r_word(32, 0, 5, 4, 2));
    // x0 result must never be forwarded
    emit(i_word(0, 0, 5, 9));
    emit(r_word(0, 0, 6, 0, 5));
    emit(r_word(0, 6, 7, 0, 0));
    emit(r_word(0, 4, 8, 6, 0));
    emit(r_word(0, 2, 9, 0, 5));
    // younger write to x10 wins
    emit(i_word(0, 10, 0, 1));
    emit(i_word(0, 10, 0, 2));
    emit(r_word(0, 0, 11, 10, 10));
    emit(ecall_word);
    run_program("bypass_chains");
  endtask

  task automatic branch_coverage();
    int f3s [6]   = '{0, 1, 4, 5, 6, 7};
    int yes_a [6] = '{1, 1, 2, 1, 1, 2};
    int yes_b [6] = '{3, 2, 1, 2, 2, 1};
    int no_a [6]  = '{1, 1, 1, 2, 2, 1};
    int no_b [6]  = '{2, 3, 2, 1, 1, 2};
    int start [6] = '{-1, 0, 0, 1, 0, 2};
    int bound [6] = '{0, 2, 2, 0, 2, 1};
    int step [6]  = '{1, 1, 1, -1, 1, -1};
    new_program();
    emit(i_word(0, 1, 0, 5));
    emit(i_word(0, 2, 0, -3));
    emit(i_word(0, 3, 0, 5));
    for (int i = 0; i < 6; i++) begin
      // forward taken over x20, forward not taken into x21
      emit(b_word(f3s[i], yes_a[i], yes_b[i], 8));
      emit(i_word(0, 20, 20, 1));
      emit(b_word(f3s[i], no_a[i], no_b[i], 8));
      emit(i_word(0, 21, 21, 1));
      // backward loop, taken once then falls through
      emit(i_word(0, 5, 0, start[i]));
      emit(i_word(0, 6, 0, bound[i]));
      emit(i_word(0, 5, 5, step[i]));
      emit(b_word(f3s[i], 5, 6, -4));
    end
    emit(ecall_word);
    run_program("branch_coverage");
  endtask

  task automatic random_reg_reg();
    int f3_of [10] = '{0, 0, 1, 2, 3, 4, 5, 5, 6, 7};
    int f7_of [10] = '{0, 32, 0, 0, 0, 0, 0, 32, 0, 0};
    int pick;
    int rd;
    int rs1;
    int rs2;
    new_program();
    for (int r = 1; r < 8; r++) begin
      emit(u_word(r, $random(seed)));
      emit(i_word(0, r, r, $random(seed)));
    end
    repeat (200) begin
      pick = $unsigned($random(seed)) % 10;
      rd = 1 + $unsigned($random(seed)) % 7;
      rs1 = 1 + $unsigned($random(seed)) % 7;
      rs2 = 1 + $unsigned($random(seed)) % 7;
      emit(r_word(f7_of[pick], f3_of[pick], rd, rs1, rs2));
    end
    emit(ecall_word);
    run_program("random_reg_reg");
  endtask

  task automatic ecall_halt();
    new_program();
    emit(i_word(0, 1, 0, 3));
    emit(i_word(0, 2, 1, 4));
    emit(ecall_word);
    // fetched behind the ecall, never reaches writeback before halt
    emit(i_word(0, 3, 0, 5));
    emit(i_word(0, 4, 0, 6));
    run_program("ecall_halt");
  endtask

  initial begin
    reset_sequence();
    immediate_ops();
    bypass_chains();
    branch_coverage();
    random_reg_reg();
    ecall_halt();
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// ==== test/tb_clock.sv ====
module tb_clock #(
  parameter real period_ns = 8.0
) (
  output logic clk
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk = 1'b0;
  end

  always begin
    #(period_ns / 2.0) clk = ~clk;
  end

endmodule

// ==== logic/rv_core.sv ====
module rv_core import rv_pkg::*; #(
  parameter logic [xlen-1:0] reset_pc = '0
) (
  input  logic                 clk,
  input  logic                 rst,
  output logic [xlen-1:0]      pc_to_imem,
  input  logic [xlen-1:0]      insn_from_imem,
  output logic                 halt,
  output logic [xlen-1:0]      trace_writeback_pc,
  output logic [xlen-1:0]      trace_writeback_insn,
  output logic [status_w-1:0]  trace_writeback_cycle_status,
  output logic                 trace_writeback_we,
  output logic [reg_idx_w-1:0] trace_writeback_rd,
  output logic [xlen-1:0]      trace_writeback_rd_data
);

  logic [status_w-1:0]  f_status, d_status, x_status;
  logic                 branch_taken;
  logic [xlen-1:0]      branch_target;
  logic [reg_idx_w-1:0] rs1, rs2;
  logic [xlen-1:0]      rf_rs1_data, rf_rs2_data;
  logic [xlen-1:0]      d_pc, d_insn, d_rs1_data, d_rs2_data;
  logic [alu_op_w-1:0]  d_alu_op;
  logic                 d_use_imm, d_writes_rd, d_is_branch, d_is_ecall;
  logic [xlen-1:0]      x_pc, x_insn, x_result;
  logic [reg_idx_w-1:0] x_rd, m_rd, w_rd;
  logic                 x_we, x_halt, m_we, w_we;
  logic [xlen-1:0]      m_data, w_data;

  fetch_unit #(.reset_pc(reset_pc)) u_fetch (
    .clk(clk), .rst(rst), .branch_taken(branch_taken), .branch_target(branch_target),
    .pc(pc_to_imem), .status(f_status)
  );

  decode_stage u_decode (
    .clk(clk), .rst(rst), .f_pc(pc_to_imem), .f_status(f_status),
    .insn_from_imem(insn_from_imem), .flush(branch_taken),
    .rf_rs1_data(rf_rs1_data), .rf_rs2_data(rf_rs2_data),
    .w_we(w_we), .w_rd(w_rd), .w_data(w_data), .rs1(rs1), .rs2(rs2),
    .d_pc(d_pc), .d_insn(d_insn), .d_status(d_status),
    .d_rs1_data(d_rs1_data), .d_rs2_data(d_rs2_data), .d_alu_op(d_alu_op),
    .d_use_imm(d_use_imm), .d_writes_rd(d_writes_rd),
    .d_is_branch(d_is_branch), .d_is_ecall(d_is_ecall)
  );

  // write port fed from writeback, same cycle as the wd bypass
  reg_file u_rf (
    .clk(clk), .rst(rst), .we(w_we), .rd(w_rd), .rd_data(w_data),
    .rs1(rs1), .rs2(rs2), .rs1_data(rf_rs1_data), .rs2_data(rf_rs2_data)
  );

  execute_stage u_execute (
    .clk(clk), .rst(rst), .d_pc(d_pc), .d_insn(d_insn), .d_status(d_status),
    .d_rs1_data(d_rs1_data), .d_rs2_data(d_rs2_data), .d_alu_op(d_alu_op),
    .d_use_imm(d_use_imm), .d_writes_rd(d_writes_rd),
    .d_is_branch(d_is_branch), .d_is_ecall(d_is_ecall),
    .m_we(m_we), .m_rd(m_rd), .m_data(m_data), .w_we(w_we), .w_rd(w_rd), .w_data(w_data),
    .branch_taken(branch_taken), .branch_target(branch_target),
    .x_pc(x_pc), .x_insn(x_insn), .x_status(x_status), .x_result(x_result),
    .x_rd(x_rd), .x_we(x_we), .x_halt(x_halt)
  );

  retire_stages u_retire (
    .clk(clk), .rst(rst), .x_pc(x_pc), .x_insn(x_insn), .x_status(x_status),
    .x_result(x_result), .x_rd(x_rd), .x_we(x_we), .x_halt(x_halt),
    .m_we(m_we), .m_rd(m_rd), .m_data(m_data), .w_we(w_we), .w_rd(w_rd), .w_data(w_data),
    .halt(halt), .trace_writeback_pc(trace_writeback_pc),
    .trace_writeback_insn(trace_writeback_insn),
    .trace_writeback_cycle_status(trace_writeback_cycle_status),
    .trace_writeback_we(trace_writeback_we), .trace_writeback_rd(trace_writeback_rd),
    .trace_writeback_rd_data(trace_writeback_rd_data)
  );

endmodule

// ==== logic/retire_stages.sv ====
module retire_stages import rv_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [xlen-1:0]      x_pc,
  input  logic [xlen-1:0]      x_insn,
  input  logic [status_w-1:0]  x_status,
  input  logic [xlen-1:0]      x_result,
  input  logic [reg_idx_w-1:0] x_rd,
  input  logic                 x_we,
  input  logic                 x_halt,
  output logic                 m_we,
  output logic [reg_idx_w-1:0] m_rd,
  output logic [xlen-1:0]      m_data,
  output logic                 w_we,
  output logic [reg_idx_w-1:0] w_rd,
  output logic [xlen-1:0]      w_data,
  output logic                 halt,
  output logic [xlen-1:0]      trace_writeback_pc,
  output logic [xlen-1:0]      trace_writeback_insn,
  output logic [status_w-1:0]  trace_writeback_cycle_status,
  output logic                 trace_writeback_we,
  output logic [reg_idx_w-1:0] trace_writeback_rd,
  output logic [xlen-1:0]      trace_writeback_rd_data
);

  logic [xlen-1:0]     m_pc, m_insn, w_pc, w_insn;
  logic [status_w-1:0] m_status, w_status;
  logic                m_halt;

  // memory stage carries no access, it only delays by one cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      m_pc     <= '0;
      m_insn   <= '0;
      m_status <= cs_reset;
      m_we     <= 1'b0;
      m_halt   <= 1'b0;
      w_pc     <= '0;
      w_insn   <= '0;
      w_status <= cs_reset;
      w_we     <= 1'b0;
      halt     <= 1'b0;
    end else begin
      m_pc     <= x_pc;
      m_insn   <= x_insn;
      m_status <= x_status;
      m_we     <= x_we;
      m_halt   <= x_halt;
      w_pc     <= m_pc;
      w_insn   <= m_insn;
      w_status <= m_status;
      w_we     <= m_we;
      halt     <= m_halt;
    end
  end

  always_ff @(posedge clk) begin
    m_rd   <= x_rd;
    m_data <= x_result;
    w_rd   <= m_rd;
    w_data <= m_data;
  end

  assign trace_writeback_pc           = w_pc;
  assign trace_writeback_insn         = w_insn;
  assign trace_writeback_cycle_status = w_status;
  assign trace_writeback_we           = w_we;
  assign trace_writeback_rd           = w_rd;
  assign trace_writeback_rd_data      = w_data;

endmodule

// ==== logic/execute_stage.sv ====
module execute_stage import rv_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [xlen-1:0]      d_pc,
  input  logic [xlen-1:0]      d_insn,
  input  logic [status_w-1:0]  d_status,
  input  logic [xlen-1:0]      d_rs1_data,
  input  logic [xlen-1:0]      d_rs2_data,
  input  logic [alu_op_w-1:0]  d_alu_op,
  input  logic                 d_use_imm,
  input  logic                 d_writes_rd,
  input  logic                 d_is_branch,
  input  logic                 d_is_ecall,
  input  logic                 m_we,
  input  logic [reg_idx_w-1:0] m_rd,
  input  logic [xlen-1:0]      m_data,
  input  logic                 w_we,
  input  logic [reg_idx_w-1:0] w_rd,
  input  logic [xlen-1:0]      w_data,
  output logic                 branch_taken,
  output logic [xlen-1:0]      branch_target,
  output logic [xlen-1:0]      x_pc,
  output logic [xlen-1:0]      x_insn,
  output logic [status_w-1:0]  x_status,
  output logic [xlen-1:0]      x_result,
  output logic [reg_idx_w-1:0] x_rd,
  output logic                 x_we,
  output logic                 x_halt
);

  insn_u                insn_q;
  logic [xlen-1:0]      rs1_q, rs2_q;
  logic [alu_op_w-1:0]  alu_op_q;
  logic                 use_imm_q, writes_rd_q, is_branch_q, is_ecall_q;
  logic [xlen-1:0]      op_a, op_b, alu_b;
  logic [xlen-1:0]      imm_i, imm_b, imm_u;
  logic                 cond;

  // memory stage is younger than writeback, so it wins
  function automatic logic [xlen-1:0] bypass(input logic [reg_idx_w-1:0] idx,
                                             input logic [xlen-1:0] reg_val);
    if (m_we && m_rd != '0 && m_rd == idx) begin
      return m_data;
    end else if (w_we && w_rd != '0 && w_rd == idx) begin
      return w_data;
    end
    return reg_val;
  endfunction

  always_ff @(posedge clk) begin
    if (rst || branch_taken) begin
      x_pc        <= '0;
      insn_q      <= '0;
      x_status    <= rst ? cs_reset : cs_taken_branch;
      writes_rd_q <= 1'b0;
      is_branch_q <= 1'b0;
      is_ecall_q  <= 1'b0;
    end else begin
      x_pc        <= d_pc;
      insn_q      <= d_insn;
      x_status    <= d_status;
      writes_rd_q <= d_writes_rd;
      is_branch_q <= d_is_branch;
      is_ecall_q  <= d_is_ecall;
    end
  end

  always_ff @(posedge clk) begin
    rs1_q     <= d_rs1_data;
    rs2_q     <= d_rs2_data;
    alu_op_q  <= d_alu_op;
    use_imm_q <= d_use_imm;
  end

  // mx and wx bypass per operand
  always_comb begin
    op_a = bypass(insn_q.r.rs1, rs1_q);
    op_b = bypass(insn_q.r.rs2, rs2_q);
  end

  assign imm_i = {{(xlen-12){insn_q.i.imm12[11]}}, insn_q.i.imm12};
  assign imm_b = {{(xlen-12){insn_q.b.imm12}}, insn_q.b.imm11, insn_q.b.imm10_5,
                  insn_q.b.imm4_1, 1'b0};
  assign imm_u = {insn_q.u.imm20, 12'b0};

  assign alu_b = !use_imm_q ? op_b : (insn_q.u.opcode == opc_lui) ? imm_u : imm_i;

  alu u_alu (
    .op     (alu_op_q),
    .a      (op_a),
    .b      (alu_b),
    .result (x_result)
  );

  always_comb begin
    case (insn_q.b.funct3)
      3'b000:  cond = op_a == op_b;
      3'b001:  cond = op_a != op_b;
      3'b100:  cond = $signed(op_a) < $signed(op_b);
      3'b101:  cond = $signed(op_a) >= $signed(op_b);
      3'b110:  cond = op_a < op_b;
      3'b111:  cond = op_a >= op_b;
      default: cond = 1'b0;
    endcase
  end

  assign branch_taken  = is_branch_q && cond;
  // target relative to the branch itself
  assign branch_target = x_pc + imm_b;

  assign x_insn = insn_q;
  assign x_rd   = insn_q.r.rd;
  assign x_we   = writes_rd_q;
  assign x_halt = is_ecall_q;

  // decode must have classified a real branch opcode
  assert property (@(posedge clk) disable iff (rst)
    branch_taken |-> insn_q.b.opcode == opc_branch)
    else $error("taken branch at pc %h without a branch opcode", x_pc);

endmodule

// ==== logic/alu.sv ====
module alu import rv_pkg::*; (
  input  logic [alu_op_w-1:0] op,
  input  logic [xlen-1:0]     a,
  input  logic [xlen-1:0]     b,
  output logic [xlen-1:0]     result
);

  logic [4:0] shamt;

  // shifts only look at the low five bits of b
  assign shamt = b[4:0];

  always_comb begin
    case (op)
      alu_add: begin
        result = a + b;
      end
      alu_sub: begin
        result = a - b;
      end
      alu_sll: begin
        result = a << shamt;
      end
      alu_slt: begin
        result = xlen'($signed(a) < $signed(b));
      end
      alu_sltu: begin
        result = xlen'(a < b);
      end
      alu_xor: begin
        result = a ^ b;
      end
      alu_srl: begin
        result = a >> shamt;
      end
      alu_sra: begin
        result = $signed(a) >>> shamt;
      end
      alu_or: begin
        result = a | b;
      end
      alu_and: begin
        result = a & b;
      end
      alu_pass_b: begin
        result = b;
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

// ==== logic/decode_stage.sv ====
module decode_stage import rv_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [xlen-1:0]      f_pc,
  input  logic [status_w-1:0]  f_status,
  input  logic [xlen-1:0]      insn_from_imem,
  input  logic                 flush,
  input  logic [xlen-1:0]      rf_rs1_data,
  input  logic [xlen-1:0]      rf_rs2_data,
  input  logic                 w_we,
  input  logic [reg_idx_w-1:0] w_rd,
  input  logic [xlen-1:0]      w_data,
  output logic [reg_idx_w-1:0] rs1,
  output logic [reg_idx_w-1:0] rs2,
  output logic [xlen-1:0]      d_pc,
  output logic [xlen-1:0]      d_insn,
  output logic [status_w-1:0]  d_status,
  output logic [xlen-1:0]      d_rs1_data,
  output logic [xlen-1:0]      d_rs2_data,
  output logic [alu_op_w-1:0]  d_alu_op,
  output logic                 d_use_imm,
  output logic                 d_writes_rd,
  output logic                 d_is_branch,
  output logic                 d_is_ecall
);

  insn_u insn_q;

  // maps funct3 to an alu op, alt picks sub or sra
  function automatic logic [alu_op_w-1:0] alu_op_of(input logic [2:0] funct3, input logic alt);
    case (funct3)
      3'b000:  return alt ? alu_sub : alu_add;
      3'b001:  return alu_sll;
      3'b010:  return alu_slt;
      3'b011:  return alu_sltu;
      3'b100:  return alu_xor;
      3'b101:  return alt ? alu_sra : alu_srl;
      3'b110:  return alu_or;
      default: return alu_and;
    endcase
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      d_pc     <= '0;
      insn_q   <= '0;
      d_status <= cs_reset;
    end else if (flush) begin
      d_pc     <= '0;
      insn_q   <= '0;
      d_status <= cs_taken_branch;
    end else begin
      d_pc     <= f_pc;
      insn_q   <= insn_from_imem;
      d_status <= f_status;
    end
  end

  assign d_insn = insn_q;
  assign rs1    = insn_q.r.rs1;
  assign rs2    = insn_q.r.rs2;

  always_comb begin
    d_alu_op    = alu_add;
    d_use_imm   = 1'b0;
    d_writes_rd = 1'b0;
    d_is_branch = 1'b0;
    d_is_ecall  = 1'b0;
    case (insn_q.r.opcode)
      opc_lui: begin
        d_alu_op    = alu_pass_b;
        d_use_imm   = 1'b1;
        d_writes_rd = 1'b1;
      end
      opc_reg_imm: begin
        // only srai carries the alt bit, addi may have it set in its immediate
        d_alu_op    = alu_op_of(insn_q.r.funct3,
                                insn_q.r.funct3 == 3'b101 && insn_q.r.funct7[5]);
        d_use_imm   = 1'b1;
        d_writes_rd = 1'b1;
      end
      opc_reg_reg: begin
        d_alu_op    = alu_op_of(insn_q.r.funct3, insn_q.r.funct7[5]);
        // m extension and other funct7 values are not supported
        d_writes_rd = insn_q.r.funct7 == 7'b0000000 || insn_q.r.funct7 == 7'b0100000;
      end
      opc_branch: begin
        d_is_branch = 1'b1;
      end
      opc_environ: begin
        d_is_ecall = insn_q.i.imm12 == '0 && insn_q.i.rs1 == '0 &&
                     insn_q.i.funct3 == '0 && insn_q.i.rd == '0;
      end
      default: begin
      end
    endcase
  end

  // wd bypass, register file is written at the end of this same cycle
  assign d_rs1_data = (w_we && w_rd != '0 && w_rd == rs1) ? w_data : rf_rs1_data;
  assign d_rs2_data = (w_we && w_rd != '0 && w_rd == rs2) ? w_data : rf_rs2_data;

endmodule

// ==== logic/reg_file.sv ====
module reg_file import rv_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 we,
  input  logic [reg_idx_w-1:0] rd,
  input  logic [xlen-1:0]      rd_data,
  input  logic [reg_idx_w-1:0] rs1,
  input  logic [reg_idx_w-1:0] rs2,
  output logic [xlen-1:0]      rs1_data,
  output logic [xlen-1:0]      rs2_data
);

  localparam int num_regs = 2 ** reg_idx_w;

  logic [xlen-1:0] regs [num_regs];

  // x0 reads as zero whatever gets written to it
  assign regs[0] = '0;

  for (genvar i = 1; i < num_regs; i++) begin : gen_regs
    logic [xlen-1:0] q;

    always_ff @(posedge clk) begin
      if (rst) begin
        q <= '0;
      end else if (we && rd == reg_idx_w'(i)) begin
        q <= rd_data;
      end
    end

    assign regs[i] = q;
  end

  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  assert property (@(posedge clk) disable iff (rst) we |-> !$isunknown(rd_data))
    else $error("register file write of unknown data to x%0d", rd);

endmodule

// ==== logic/fetch_unit.sv ====
module fetch_unit import rv_pkg::*; #(
  parameter logic [xlen-1:0] reset_pc = '0
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                branch_taken,
  input  logic [xlen-1:0]     branch_target,
  output logic [xlen-1:0]     pc,
  output logic [status_w-1:0] status
);

  always_ff @(posedge clk) begin
    if (rst) begin
      pc     <= reset_pc;
      // fetch slot is already valid in the first cycle after reset
      status <= cs_no_stall;
    end else begin
      // redirect from execute wins over sequential fetch
      if (branch_taken) begin
        pc <= branch_target;
      end else begin
        pc <= pc + xlen'(4);
      end
      status <= cs_no_stall;
    end
  end

  // every redirect target must keep the fetch pc word aligned
  assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else $error("fetch pc %h is not word aligned", pc);

endmodule

// ==== logic/rv_pkg.sv ====
package rv_pkg;

  localparam int xlen      = 32;
  localparam int reg_idx_w = 5;

  // major opcodes of the supported subset
  localparam logic [6:0] opc_lui     = 7'b0110111;
  localparam logic [6:0] opc_reg_imm = 7'b0010011;
  localparam logic [6:0] opc_reg_reg = 7'b0110011;
  localparam logic [6:0] opc_branch  = 7'b1100011;
  localparam logic [6:0] opc_environ = 7'b1110011;

  localparam int alu_op_w = 4;

  localparam logic [alu_op_w-1:0] alu_add    = 4'd0;
  localparam logic [alu_op_w-1:0] alu_sub    = 4'd1;
  localparam logic [alu_op_w-1:0] alu_sll    = 4'd2;
  localparam logic [alu_op_w-1:0] alu_slt    = 4'd3;
  localparam logic [alu_op_w-1:0] alu_sltu   = 4'd4;
  localparam logic [alu_op_w-1:0] alu_xor    = 4'd5;
  localparam logic [alu_op_w-1:0] alu_srl    = 4'd6;
  localparam logic [alu_op_w-1:0] alu_sra    = 4'd7;
  localparam logic [alu_op_w-1:0] alu_or     = 4'd8;
  localparam logic [alu_op_w-1:0] alu_and    = 4'd9;
  // lui result is the operand b as built by execute
  localparam logic [alu_op_w-1:0] alu_pass_b = 4'd10;

  // one-hot cycle status seen on the writeback trace
  localparam int status_w = 3;

  localparam logic [status_w-1:0] cs_reset        = 3'd1;
  localparam logic [status_w-1:0] cs_no_stall     = 3'd2;
  localparam logic [status_w-1:0] cs_taken_branch = 3'd4;

  typedef struct packed {
    logic [6:0]           funct7;
    logic [reg_idx_w-1:0] rs2;
    logic [reg_idx_w-1:0] rs1;
    logic [2:0]           funct3;
    logic [reg_idx_w-1:0] rd;
    logic [6:0]           opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0]          imm12;
    logic [reg_idx_w-1:0] rs1;
    logic [2:0]           funct3;
    logic [reg_idx_w-1:0] rd;
    logic [6:0]           opcode;
  } i_fmt_t;

  // branch offset bits are scattered around the register fields
  typedef struct packed {
    logic                 imm12;
    logic [5:0]           imm10_5;
    logic [reg_idx_w-1:0] rs2;
    logic [reg_idx_w-1:0] rs1;
    logic [2:0]           funct3;
    logic [3:0]           imm4_1;
    logic                 imm11;
    logic [6:0]           opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0]          imm20;
    logic [reg_idx_w-1:0] rd;
    logic [6:0]           opcode;
  } u_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    b_fmt_t b;
    u_fmt_t u;
  } insn_u;

endpackage
